//--- bench/tb_clock.sv
`timescale 1ns/10ps
//----------------------------------------------------------
// 4 ns clock, rst_n low over the first 4 rising edges
//----------------------------------------------------------
module tb_clock (
   output logic clk_in,
   output logic rst_n
);

   initial begin
      clk_in = 1'b0;
      forever #2 clk_in = ~clk_in;                           // 250 MHz
   end

   initial begin
      rst_n = 1'b0;
      repeat (4) @(posedge clk_in);
      rst_n <= 1'b1;                                         // Released on an edge
   end

endmodule

//--- bench/tb_mmio.sv
`timescale 1ns/10ps
//----------------------------------------------------------
// Cache and I/O responders ack 1 to 4 cycles after their req
// One access at a time, req dropped on the edge that sees ack
//----------------------------------------------------------
module tb_mmio;
   import mmio_pkg::*;

   localparam logic [31:0] SEED    = 32'h7ea21693;
   localparam logic [31:0] DC_KEY  = 32'hA5A5_0F0F;          // Cache data = addr ^ key
   localparam logic [31:0] IO_KEY  = 32'h5A5A_F0F0;          // I/O data = addr ^ key
   localparam int          IRQ_MAX = 60;                     // Cycles allowed for time_irq
   localparam int          TIMEOUT = 2000;                   // 34 accesses x 8 + irq wait, margin

   logic clk_in;
   logic rst_n;

   // DUT inputs
   logic              req          = 1'b0;
   logic [ADDR_W-1:0] addr         = '0;
   logic              rd           = 1'b0;
   logic              wr           = 1'b0;
   logic [DATA_W-1:0] wr_data      = '0;
   logic              dc_ack       = 1'b0;
   logic [DATA_W-1:0] dc_ack_data  = '0;
   logic              io_ack       = 1'b0;
   logic              io_ack_fault = 1'b0;
   logic [DATA_W-1:0] io_rd_data   = '0;

   // DUT outputs
   logic ack, ack_fault, dc_req, dc_rd, dc_wr, io_req, io_rd, io_wr, time_irq, sw_irq;
   logic [31:0] ack_data, dc_addr, dc_wr_data, io_addr, io_wr_data;

   // Expected state and bookkeeping
   target_e     exp_tgt   = TGT_FAULT;                       // Route of the access in flight
   logic        exp_msip  = 1'b0;
   logic        irq_armed = 1'b0;                            // Waiting for time_irq
   int          irq_wait  = 0;
   int          cycles    = 0;
   int          errors    = 0;
   int          accesses  = 0;
   logic [31:0] stim_rng  = SEED;
   logic [31:0] dc_rng    = SEED;
   logic [31:0] io_rng    = SEED;
   logic [1:0]  dc_wait;
   logic [1:0]  io_wait;
   logic        dc_busy   = 1'b0;
   logic        io_busy   = 1'b0;
   logic        cmp_off;                                     // mtimecmp high set to all ones

   tb_clock clock_gen (.clk_in(clk_in), .rst_n(rst_n));

   mmio_core dut (.*);

   assign cmp_off = ack && wr && (addr == MTIMECMP_ADDR + 4) && (wr_data == 32'hFFFF_FFFF);

   //----------------------------------------------------------
   // Helpers
   //----------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Destination from the address map
   function automatic target_e route_of(input logic [31:0] a);
      if (a[1:0] != 2'b00)
         return TGT_FAULT;                                   // Misaligned
      if (a >= MEM_LO && a <= MEM_HI)
         return TGT_MEM;
      if (a >= EXT_IO_LO && a <= EXT_IO_HI)
         return TGT_EXT;
      if (a == MSIP_ADDR || a == MTIME_ADDR || a == MTIME_ADDR + 4 ||
          a == MTIMECMP_ADDR || a == MTIMECMP_ADDR + 4)
         return TGT_INT;
      return TGT_FAULT;                                      // Unmapped or unused offset
   endfunction

   task automatic log_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] want);
      errors++;
      $display("mismatch %s: got %0h expected %0h", name, got, want);
   endtask

   task automatic flag_problem(input string what);
      errors++;
      $display("error: %s", what);
   endtask

   // One access, held until ack
   task automatic bus_access(input logic is_wr, input logic [31:0] a, input logic [31:0] d);
      @(posedge clk_in);
      req     <= 1'b1;
      addr    <= a;
      rd      <= !is_wr;
      wr      <= is_wr;
      wr_data <= d;
      exp_tgt <= route_of(a);
      accesses++;
      @(posedge clk_in);
      while (!ack)
         @(posedge clk_in);
      req <= 1'b0;
      rd  <= 1'b0;
      wr  <= 1'b0;
      if (is_wr && a == MSIP_ADDR)
         exp_msip <= d[0];                                   // Lands on this same edge
   endtask

   //----------------------------------------------------------
   // Responders
   //----------------------------------------------------------
   always @(posedge clk_in) begin
      if (!rst_n || dc_ack) begin
         dc_ack  <= 1'b0;
         dc_busy <= 1'b0;
      end else if (dc_req && !dc_busy) begin
         dc_rng  <= xorshift32(dc_rng);
         dc_wait <= dc_rng[1:0];                             // 0 to 3 extra cycles
         dc_busy <= 1'b1;
      end else if (dc_busy && dc_wait != 2'd0) begin
         dc_wait <= dc_wait - 1'b1;
      end else if (dc_busy) begin
         dc_ack      <= 1'b1;
         dc_ack_data <= dc_addr ^ DC_KEY;
      end
   end

   always @(posedge clk_in) begin
      if (!rst_n || io_ack) begin
         io_ack  <= 1'b0;
         io_busy <= 1'b0;
      end else if (io_req && !io_busy) begin
         io_rng  <= xorshift32(io_rng);
         io_wait <= io_rng[2:1];
         io_busy <= 1'b1;
      end else if (io_busy && io_wait != 2'd0) begin
         io_wait <= io_wait - 1'b1;
      end else if (io_busy) begin
         io_ack       <= 1'b1;
         io_ack_fault <= io_addr[4];                         // Device fault on bit 4
         io_rd_data   <= io_addr ^ IO_KEY;
      end
   end

   // Cycle limit and wait counter for the timer interrupt
   always @(posedge clk_in) begin
      cycles <= cycles + 1;
      if (irq_armed && !time_irq)
         irq_wait <= irq_wait + 1;
      if (cycles == TIMEOUT) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT);
         $display("accesses %0d, errors %0d", accesses, errors);
         $display("Checks failed");
         $finish;
      end
   end

   //----------------------------------------------------------
   // Checks
   //----------------------------------------------------------
   a_mem_start: assert property (@(posedge clk_in) disable iff (!rst_n)
      (req && !$past(req) && exp_tgt == TGT_MEM) |=> dc_req)
      else flag_problem("dc_req did not rise one cycle after a memory request");
   a_ext_start: assert property (@(posedge clk_in) disable iff (!rst_n)
      (req && !$past(req) && exp_tgt == TGT_EXT) |=> io_req)
      else flag_problem("io_req did not rise one cycle after an external request");
   a_short_ack: assert property (@(posedge clk_in) disable iff (!rst_n)
      (req && !$past(req) && (exp_tgt == TGT_INT || exp_tgt == TGT_FAULT)) |=> ack)
      else flag_problem("no ack one cycle after an internal or faulting request");
   a_ack_pulse: assert property (@(posedge clk_in) disable iff (!rst_n) ack |=> !ack)
      else flag_problem("ack held for more than one cycle");

   // Routing and outgoing request fields
   a_dc_route: assert property (@(posedge clk_in) disable iff (!rst_n)
      dc_req |-> exp_tgt == TGT_MEM) else flag_problem("dc_req raised outside the cache range");
   a_io_route: assert property (@(posedge clk_in) disable iff (!rst_n)
      io_req |-> exp_tgt == TGT_EXT) else flag_problem("io_req raised outside the I/O range");
   a_dc_addr: assert property (@(posedge clk_in) disable iff (!rst_n) dc_req |-> dc_addr == addr)
      else log_mismatch("dc_addr", $sampled(dc_addr), $sampled(addr));
   a_dc_ctl: assert property (@(posedge clk_in) disable iff (!rst_n)
      dc_req |-> {dc_rd, dc_wr, dc_wr_data} == {rd, wr, wr_data})
      else log_mismatch("dc_rd/dc_wr/dc_wr_data", $sampled({dc_rd, dc_wr, dc_wr_data}),
                        $sampled({rd, wr, wr_data}));
   a_io_addr: assert property (@(posedge clk_in) disable iff (!rst_n) io_req |-> io_addr == addr)
      else log_mismatch("io_addr", $sampled(io_addr), $sampled(addr));
   a_io_ctl: assert property (@(posedge clk_in) disable iff (!rst_n)
      io_req |-> {io_rd, io_wr, io_wr_data} == {rd, wr, wr_data})
      else log_mismatch("io_rd/io_wr/io_wr_data", $sampled({io_rd, io_wr, io_wr_data}),
                        $sampled({rd, wr, wr_data}));

   // Responses
   a_fault: assert property (@(posedge clk_in) disable iff (!rst_n)
      (ack && exp_tgt != TGT_EXT) |-> ack_fault == (exp_tgt == TGT_FAULT))
      else log_mismatch("ack_fault", $sampled(ack_fault), $sampled(exp_tgt == TGT_FAULT));
   a_ext_fault: assert property (@(posedge clk_in) disable iff (!rst_n)
      (ack && exp_tgt == TGT_EXT) |-> ack_fault == addr[4])
      else log_mismatch("ack_fault", $sampled(ack_fault), $sampled(addr[4]));
   a_mem_data: assert property (@(posedge clk_in) disable iff (!rst_n)
      (ack && rd && exp_tgt == TGT_MEM) |-> ack_data == (addr ^ DC_KEY))
      else log_mismatch("ack_data", $sampled(ack_data), $sampled(addr) ^ DC_KEY);
   a_ext_data: assert property (@(posedge clk_in) disable iff (!rst_n)
      (ack && rd && exp_tgt == TGT_EXT) |-> ack_data == (addr ^ IO_KEY))
      else log_mismatch("ack_data", $sampled(ack_data), $sampled(addr) ^ IO_KEY);

   // Software interrupt and timer
   a_sw_irq: assert property (@(posedge clk_in) disable iff (!rst_n) sw_irq == exp_msip)
      else log_mismatch("sw_irq", $sampled(sw_irq), $sampled(exp_msip));
   a_msip_read: assert property (@(posedge clk_in) disable iff (!rst_n)
      (ack && rd && addr == MSIP_ADDR) |-> ack_data == {31'b0, exp_msip})
      else log_mismatch("ack_data", $sampled(ack_data), $sampled({31'b0, exp_msip}));
   a_mtime_read: assert property (@(posedge clk_in) disable iff (!rst_n)
      (ack && rd && addr == MTIME_ADDR) |-> (ack_data > 0 && ack_data < 10))
      else begin
         errors++;
         $display("mismatch ack_data: got %h expected %h to %h", $sampled(ack_data), 1, 9);
      end
   a_irq_reset: assert property (@(posedge clk_in) $rose(rst_n) |-> !time_irq)
      else flag_problem("time_irq high right after reset");
   a_irq_rise: assert property (@(posedge clk_in) disable iff (!rst_n)
      (irq_armed && !time_irq) |-> irq_wait < IRQ_MAX)
      else flag_problem("time_irq did not rise within 60 cycles of the mtimecmp write");
   a_irq_drop: assert property (@(posedge clk_in) disable iff (!rst_n)
      $past(cmp_off, 2) |-> !time_irq)
      else flag_problem("time_irq stayed high after mtimecmp was pushed out");

   //----------------------------------------------------------
   // Stimulus
   //----------------------------------------------------------
   initial begin
      wait (rst_n);
      repeat (8) begin                                       // Cache range
         stim_rng = xorshift32(stim_rng);
         bus_access(stim_rng[31], {16'h0000, stim_rng[15:2], 2'b00}, stim_rng ^ SEED);
      end
      repeat (8) begin                                       // External range
         stim_rng = xorshift32(stim_rng);
         bus_access(stim_rng[30], {16'h8000, stim_rng[15:2], 2'b00}, ~stim_rng);
      end
      bus_access(1'b0, 32'h8000_0010, '0);                   // Device fault
      bus_access(1'b0, 32'h0000_0102, '0);                   // Misaligned
      bus_access(1'b1, 32'h8000_0003, 32'h1);
      bus_access(1'b0, 32'h4000_0000, '0);                   // Unmapped
      bus_access(1'b0, 32'hFFFF_0004, '0);                   // Unused internal offset
      bus_access(1'b1, 32'hFFFF_0100, 32'h1);
      bus_access(1'b1, MSIP_ADDR, 32'h0000_0001);
      bus_access(1'b0, MSIP_ADDR, '0);
      bus_access(1'b1, MSIP_ADDR, 32'hFFFF_FFFE);
      bus_access(1'b0, MSIP_ADDR, '0);
      bus_access(1'b1, MSIP_ADDR, 32'h8000_0003);
      bus_access(1'b0, MSIP_ADDR, '0);
      // Zero mtime, read it back, then bring the compare close
      bus_access(1'b1, MTIME_ADDR + 4, '0);
      bus_access(1'b1, MTIME_ADDR, '0);
      bus_access(1'b0, MTIME_ADDR, '0);
      bus_access(1'b1, MTIMECMP_ADDR + 4, '0);
      bus_access(1'b1, MTIMECMP_ADDR, 32'd40);
      irq_armed <= 1'b1;
      while (!time_irq && irq_wait < IRQ_MAX)
         @(posedge clk_in);
      irq_armed <= 1'b0;
      bus_access(1'b1, MTIMECMP_ADDR + 4, 32'hFFFF_FFFF);   // Far future again
      repeat (4) @(posedge clk_in);
      $display("accesses %0d, errors %0d", accesses, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

//--- files.f
rtl/mmio_pkg.sv
rtl/mmr_if.sv
rtl/mem_io_router.sv
rtl/clint_regs.sv
rtl/mmio_core.sv
bench/tb_clock.sv
bench/tb_mmio.sv

//--- rtl/clint_regs.sv
`timescale 1ns/10ps
//----------------------------------------------------------
// mtime counts every clock, a half write replaces that count
// Only msip bit 0 exists, other bits read back as zero
//----------------------------------------------------------
module clint_regs (
   input  logic clk_in,
   input  logic rst_n,

   mmr_if.regs  mmr,                                         // Access from the router

   output logic time_irq,                                    // mtime >= mtimecmp
   output logic sw_irq                                       // msip bit 0
);
   import mmio_pkg::*;

   logic [2*DATA_W-1:0] mtime;
   logic [2*DATA_W-1:0] mtimecmp;
   logic                msip;
   logic                wr_msip;
   logic                wr_mtime_lo;
   logic                wr_mtime_hi;
   logic                wr_cmp_lo;
   logic                wr_cmp_hi;

   // Write strobes per register
   assign wr_msip     = mmr.wr && (mmr.sel == MMR_MSIP);
   assign wr_mtime_lo = mmr.wr && (mmr.sel == MMR_MTIME_LO);
   assign wr_mtime_hi = mmr.wr && (mmr.sel == MMR_MTIME_HI);
   assign wr_cmp_lo   = mmr.wr && (mmr.sel == MMR_MTIMECMP_LO);
   assign wr_cmp_hi   = mmr.wr && (mmr.sel == MMR_MTIMECMP_HI);

   //----------------------------------------------------------
   // Timer
   //----------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (!rst_n)
         mtime <= '0;
      else if (wr_mtime_lo)
         mtime <= {mtime[2*DATA_W-1:DATA_W], mmr.wr_data};  // No count this cycle
      else if (wr_mtime_hi)
         mtime <= {mmr.wr_data, mtime[DATA_W-1:0]};
      else
         mtime <= mtime + 1'b1;                              // Free running
   end

   always_ff @(posedge clk_in) begin
      if (!rst_n)
         mtimecmp <= '1;                                     // Far future, no irq
      else if (wr_cmp_lo)
         mtimecmp <= {mtimecmp[2*DATA_W-1:DATA_W], mmr.wr_data};
      else if (wr_cmp_hi)
         mtimecmp <= {mmr.wr_data, mtimecmp[DATA_W-1:0]};
   end

   // Timer interrupt level, one flop after the compare
   always_ff @(posedge clk_in) begin
      if (!rst_n)
         time_irq <= 1'b0;
      else
         time_irq <= (mtime >= mtimecmp);
   end

   //----------------------------------------------------------
   // Software interrupt
   //----------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (!rst_n)
         msip <= 1'b0;
      else if (wr_msip)
         msip <= mmr.wr_data[0];
   end

   assign sw_irq = msip;                                     // Straight from the flop

   // Read mux
   always_comb begin
      case (mmr.sel)
         MMR_MSIP:        mmr.rd_data = {{(DATA_W-1){1'b0}}, msip};
         MMR_MTIME_LO:    mmr.rd_data = mtime[DATA_W-1:0];
         MMR_MTIME_HI:    mmr.rd_data = mtime[2*DATA_W-1:DATA_W];
         MMR_MTIMECMP_LO: mmr.rd_data = mtimecmp[DATA_W-1:0];
         MMR_MTIMECMP_HI: mmr.rd_data = mtimecmp[2*DATA_W-1:DATA_W];
         default:         mmr.rd_data = '0;
      endcase
   end

   // Write from the router shows up on the interrupt pin next cycle
   a_msip_to_irq: assert property (@(posedge clk_in) disable iff (!rst_n)
      wr_msip |=> (sw_irq == $past(mmr.wr_data[0])));

endmodule

//--- rtl/mem_io_router.sv
`timescale 1ns/10ps
//----------------------------------------------------------
// One access in flight, req and its fields held until ack
// Internal and fault accesses ack one cycle after req
//----------------------------------------------------------
module mem_io_router (
   input  logic                        clk_in,
   input  logic                        rst_n,

   // Load/store requester
   input  logic                        req,                  // Held until ack
   input  logic [mmio_pkg::ADDR_W-1:0] addr,
   input  logic                        rd,
   input  logic                        wr,
   input  logic [mmio_pkg::DATA_W-1:0] wr_data,
   output logic                        ack,                  // One-cycle pulse
   output logic                        ack_fault,
   output logic [mmio_pkg::DATA_W-1:0] ack_data,

   // L1 data cache
   output logic                        dc_req,               // High until dc_ack
   output logic [mmio_pkg::ADDR_W-1:0] dc_addr,
   output logic                        dc_rd,
   output logic                        dc_wr,
   output logic [mmio_pkg::DATA_W-1:0] dc_wr_data,
   input  logic                        dc_ack,
   input  logic [mmio_pkg::DATA_W-1:0] dc_ack_data,

   // External I/O
   output logic                        io_req,               // High until io_ack
   output logic [mmio_pkg::ADDR_W-1:0] io_addr,
   output logic                        io_rd,
   output logic                        io_wr,
   output logic [mmio_pkg::DATA_W-1:0] io_wr_data,
   input  logic                        io_ack,
   input  logic                        io_ack_fault,
   input  logic [mmio_pkg::DATA_W-1:0] io_rd_data,

   mmr_if.router                       mmr                   // Timer/msip registers
);
   import mmio_pkg::*;

   router_state_e     state;
   target_e           tgt;                                   // Decoded destination
   mmr_sel_e          sel_dec;                               // Register named by addr
   logic              int_hit;                               // addr names a real register
   mmr_sel_e          sel_q;
   logic              mmr_wr_q;
   logic [ADDR_W-1:0] addr_q;
   logic              rd_q;
   logic              wr_q;
   logic [DATA_W-1:0] wr_data_q;

   //----------------------------------------------------------
   // Address decode
   //----------------------------------------------------------
   always_comb begin
      sel_dec = MMR_MSIP;
      int_hit = 1'b1;
      case (addr)
         MSIP_ADDR:             sel_dec = MMR_MSIP;
         MTIME_ADDR:            sel_dec = MMR_MTIME_LO;
         MTIME_ADDR + 32'd4:    sel_dec = MMR_MTIME_HI;
         MTIMECMP_ADDR:         sel_dec = MMR_MTIMECMP_LO;
         MTIMECMP_ADDR + 32'd4: sel_dec = MMR_MTIMECMP_HI;
         default:               int_hit = 1'b0;           // Unused internal offset
      endcase

      if (addr[1:0] != 2'b00)
         tgt = TGT_FAULT;                                    // Word accesses only
      else if (addr inside {[MEM_LO:MEM_HI]})
         tgt = TGT_MEM;
      else if (addr inside {[EXT_IO_LO:EXT_IO_HI]})
         tgt = TGT_EXT;
      else if (addr inside {[INT_IO_LO:INT_IO_HI]})
         tgt = int_hit ? TGT_INT : TGT_FAULT;
      else
         tgt = TGT_FAULT;                                    // Unmapped
   end

   // Read path uses the live decode, the delayed write uses the captured select
   assign mmr.sel     = (state == ST_RESP) ? sel_q : sel_dec;
   assign mmr.wr      = mmr_wr_q;
   assign mmr.wr_data = wr_data_q;

   //----------------------------------------------------------
   // Request FSM
   //----------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         ack       <= 1'b0;
         ack_fault <= 1'b0;
         dc_req    <= 1'b0;
         io_req    <= 1'b0;
         mmr_wr_q  <= 1'b0;
      end else begin
         ack       <= 1'b0;                                  // Pulses by default
         ack_fault <= 1'b0;
         mmr_wr_q  <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (req) begin
                  state <= (tgt == TGT_MEM) ? ST_MEM_WAIT :
                           (tgt == TGT_EXT) ? ST_EXT_WAIT : ST_RESP;
                  dc_req    <= (tgt == TGT_MEM);
                  io_req    <= (tgt == TGT_EXT);
                  ack       <= (tgt == TGT_INT) || (tgt == TGT_FAULT);
                  ack_fault <= (tgt == TGT_FAULT);
                  mmr_wr_q  <= (tgt == TGT_INT) && wr;       // Lands one edge later
               end
            end
            ST_MEM_WAIT: begin
               if (dc_ack) begin
                  dc_req <= 1'b0;
                  ack    <= 1'b1;
                  state  <= ST_RESP;
               end
            end
            ST_EXT_WAIT: begin
               if (io_ack) begin
                  io_req    <= 1'b0;
                  ack       <= 1'b1;
                  ack_fault <= io_ack_fault;                 // Device side fault
                  state     <= ST_RESP;
               end
            end
            default: state <= ST_IDLE;                       // ST_RESP, req still held here
         endcase
      end
   end

   // Request fields and response data
   always_ff @(posedge clk_in) begin
      if ((state == ST_IDLE) && req) begin
         addr_q    <= addr;
         rd_q      <= rd;
         wr_q      <= wr;
         wr_data_q <= wr_data;
         sel_q     <= sel_dec;
      end
      case (state)
         ST_IDLE:     ack_data <= (tgt == TGT_INT) ? mmr.rd_data : '0;
         ST_MEM_WAIT: ack_data <= dc_ack_data;
         ST_EXT_WAIT: ack_data <= io_rd_data;
         default:     ack_data <= ack_data;                  // Hold through ack
      endcase
   end

   assign dc_addr    = addr_q;
   assign dc_rd      = rd_q;
   assign dc_wr      = wr_q;
   assign dc_wr_data = wr_data_q;
   assign io_addr    = addr_q;
   assign io_rd      = rd_q;
   assign io_wr      = wr_q;
   assign io_wr_data = wr_data_q;

   a_fault_needs_ack: assert property (@(posedge clk_in) disable iff (!rst_n)
      ack_fault |-> ack);
   a_one_port_busy: assert property (@(posedge clk_in) disable iff (!rst_n)
      !(dc_req && io_req));

endmodule

//--- rtl/mmio_core.sv
`timescale 1ns/10ps
//----------------------------------------------------------
// Memory/I/O router and core-local timer block, plain ports
//----------------------------------------------------------
module mmio_core (
   input  logic                        clk_in,
   input  logic                        rst_n,

   // Load/store requester
   input  logic                        req,
   input  logic [mmio_pkg::ADDR_W-1:0] addr,
   input  logic                        rd,
   input  logic                        wr,
   input  logic [mmio_pkg::DATA_W-1:0] wr_data,
   output logic                        ack,
   output logic                        ack_fault,
   output logic [mmio_pkg::DATA_W-1:0] ack_data,

   // L1 data cache
   output logic                        dc_req,
   output logic [mmio_pkg::ADDR_W-1:0] dc_addr,
   output logic                        dc_rd,
   output logic                        dc_wr,
   output logic [mmio_pkg::DATA_W-1:0] dc_wr_data,
   input  logic                        dc_ack,
   input  logic [mmio_pkg::DATA_W-1:0] dc_ack_data,

   // External I/O
   output logic                        io_req,
   output logic [mmio_pkg::ADDR_W-1:0] io_addr,
   output logic                        io_rd,
   output logic                        io_wr,
   output logic [mmio_pkg::DATA_W-1:0] io_wr_data,
   input  logic                        io_ack,
   input  logic                        io_ack_fault,
   input  logic [mmio_pkg::DATA_W-1:0] io_rd_data,

   // Interrupt levels
   output logic                        time_irq,
   output logic                        sw_irq
);

   mmr_if mmr ();                                            // Router <-> registers

   //----------------------------------------------------------
   // Address router
   //----------------------------------------------------------
   mem_io_router router (
      .clk_in(clk_in), .rst_n(rst_n),
      .req(req), .addr(addr), .rd(rd), .wr(wr), .wr_data(wr_data),
      .ack(ack), .ack_fault(ack_fault), .ack_data(ack_data),
      .dc_req(dc_req), .dc_addr(dc_addr), .dc_rd(dc_rd), .dc_wr(dc_wr),
      .dc_wr_data(dc_wr_data), .dc_ack(dc_ack), .dc_ack_data(dc_ack_data),
      .io_req(io_req), .io_addr(io_addr), .io_rd(io_rd), .io_wr(io_wr),
      .io_wr_data(io_wr_data), .io_ack(io_ack), .io_ack_fault(io_ack_fault),
      .io_rd_data(io_rd_data),
      .mmr(mmr.router)
   );

   // Timer and software interrupt registers
   clint_regs clint (
      .clk_in(clk_in), .rst_n(rst_n),
      .mmr(mmr.regs),
      .time_irq(time_irq),                                   // To the core interrupt logic
      .sw_irq(sw_irq)
   );

endmodule

//--- rtl/mmio_pkg.sv
//----------------------------------------------------------
// Fixed address map, word accesses only (32-bit aligned)
// Address ranges must not overlap, none are checked here
//----------------------------------------------------------
package mmio_pkg;

   //----------------------------------------------------------
   // Widths
   //----------------------------------------------------------
   localparam int ADDR_W = 32;                               // Load/store address
   localparam int DATA_W = 32;                               // Data word

   //----------------------------------------------------------
   // Address map
   //----------------------------------------------------------
   localparam logic [ADDR_W-1:0] MEM_LO        = 32'h0000_0000;  // L1 data cache
   localparam logic [ADDR_W-1:0] MEM_HI        = 32'h0000_FFFF;
   localparam logic [ADDR_W-1:0] EXT_IO_LO     = 32'h8000_0000;  // External I/O devices
   localparam logic [ADDR_W-1:0] EXT_IO_HI     = 32'h8000_FFFF;
   localparam logic [ADDR_W-1:0] INT_IO_LO     = 32'hFFFF_0000;  // Core-local registers
   localparam logic [ADDR_W-1:0] INT_IO_HI     = 32'hFFFF_00FF;

   // Internal registers, 64-bit ones as low word then high word
   localparam logic [ADDR_W-1:0] MSIP_ADDR     = 32'hFFFF_0000;
   localparam logic [ADDR_W-1:0] MTIME_ADDR    = 32'hFFFF_0008;
   localparam logic [ADDR_W-1:0] MTIMECMP_ADDR = 32'hFFFF_0010;

   // Internal register named by a router access
   typedef enum logic [2:0] {
      MMR_MSIP,
      MMR_MTIME_LO,
      MMR_MTIME_HI,
      MMR_MTIMECMP_LO,
      MMR_MTIMECMP_HI
   } mmr_sel_e;

   // Decoded destination of an access
   typedef enum logic [1:0] {TGT_MEM, TGT_EXT, TGT_INT, TGT_FAULT} target_e;

   // Router FSM
   typedef enum logic [1:0] {
      ST_IDLE,                                               // Waiting for req
      ST_MEM_WAIT,                                           // dc_req out, waiting dc_ack
      ST_EXT_WAIT,                                           // io_req out, waiting io_ack
      ST_RESP                                                // ack pulse cycle
   } router_state_e;

endpackage

//--- rtl/mmr_if.sv
`timescale 1ns/10ps
//----------------------------------------------------------
// Router to register block, rd_data is combinational on sel
//----------------------------------------------------------
interface mmr_if;
   import mmio_pkg::*;

   logic              wr;                                    // Write strobe, one cycle
   mmr_sel_e          sel;                                   // Target register
   logic [DATA_W-1:0] wr_data;
   logic [DATA_W-1:0] rd_data;                               // Contents of sel register

   // Router side
   modport router (output wr, output sel, output wr_data, input rd_data);

   // Register block side
   modport regs (input wr, input sel, input wr_data, output rd_data);

endinterface

//--- run.sh
#!/bin/sh
# Build tb_mmio with Verilator, run it into sim.log, decide on the pass line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mmio -f files.f \
   && ./obj_dir/Vtb_mmio > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
